// ==== vlsu_top.f ====
hw/vlsu_pkg.sv
hw/vlsu_sequencer.sv
hw/vlsu_address_stage.sv
hw/vlsu_return_stage.sv
hw/vlsu_top.sv
verif/vlsu_checker.sv
verif/vlsu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector load/store unit testbench with Verilator.
# Exits non-zero unless the simulation log reports a clean run.
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module vlsu_tb -Mdir obj_dir -f vlsu_top.f

./obj_dir/Vvlsu_tb > sim.log 2>&1
cat sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// ==== verif/vlsu_tb.sv ====
// Testbench for the vector load/store unit. Runs random transfers from a
// fixed seed, models a memory with one-cycle read latency, and prints the
// checker's counts at the end.

`timescale 1ns/1ps
`default_nettype none

module vlsu_tb
    import vlsu_pkg::*;
#(
    parameter int VLEN = 128
);

    localparam int IDX_W       = $clog2(VLEN / 8);
    localparam int N_XFER      = 60;
    localparam int MAX_VL      = VLEN / 8;
    // One transfer plus an idle cycle fits in vl+4 cycles
    localparam int CYCLE_LIMIT = N_XFER * (MAX_VL + 4) + 100;

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 start;
    lsu_op_e              op;
    addr_mode_e           mode;
    elem_width_e          width;
    logic [31:0]          base_addr;
    logic [31:0]          stride;
    logic [IDX_W:0]       vl;
    logic                 vm;
    logic [VLEN/8-1:0]    mask;
    logic [VLEN-1:0]      store_data;
    logic [VLEN-1:0]      index;
    logic [31:0]          mem_addr;
    logic                 mem_read_en;
    logic [BUS_BYTES-1:0] mem_write_en;
    logic [BUS_WIDTH-1:0] mem_write_data;
    logic [BUS_WIDTH-1:0] mem_read_data = '0;
    logic                 busy;
    logic                 done;
    logic [VLEN-1:0]      read_data;
    int                   check_count;
    int                   error_count;

    logic [31:0]          seed = 32'd18670;
    int                   cycles = 0;
    logic                 rd_pending = 1'b0;
    logic [31:0]          rd_addr_q = '0;

    always #20 clk = ~clk;

    vlsu_top #(.VLEN(VLEN)) u_dut (
        .clk              (clk),
        .reset_n          (reset_n),
        .start_i          (start),
        .op_i             (op),
        .mode_i           (mode),
        .width_i          (width),
        .base_addr_i      (base_addr),
        .stride_i         (stride),
        .vl_i             (vl),
        .vm_i             (vm),
        .mask_i           (mask),
        .store_data_i     (store_data),
        .index_i          (index),
        .mem_addr_o       (mem_addr),
        .mem_read_en_o    (mem_read_en),
        .mem_write_en_o   (mem_write_en),
        .mem_write_data_o (mem_write_data),
        .mem_read_data_i  (mem_read_data),
        .busy_o           (busy),
        .done_o           (done),
        .read_data_o      (read_data)
    );

    vlsu_checker #(.VLEN(VLEN)) u_checker (
        .clk              (clk),
        .reset_n          (reset_n),
        .start_i          (start),
        .op_i             (op),
        .mode_i           (mode),
        .width_i          (width),
        .base_addr_i      (base_addr),
        .stride_i         (stride),
        .vl_i             (vl),
        .vm_i             (vm),
        .mask_i           (mask),
        .store_data_i     (store_data),
        .index_i          (index),
        .mem_addr_i       (mem_addr),
        .mem_read_en_i    (mem_read_en),
        .mem_write_en_i   (mem_write_en),
        .mem_write_data_i (mem_write_data),
        .busy_i           (busy),
        .done_i           (done),
        .read_data_i      (read_data),
        .check_count_o    (check_count),
        .error_count_o    (error_count)
    );

    // Upper halves of two LCG steps form one word
    function automatic logic [31:0] rand32();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ 32'h5bd1_e995;
        h = h * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    //////////////////////////////
    // Memory model
    //////////////////////////////

    always @(negedge clk) begin
        rd_pending <= mem_read_en;
        rd_addr_q  <= mem_addr;
    end

    // Idle cycles return junk that must never reach the image
    always @(posedge clk) begin
        #2;
        mem_read_data = rd_pending ? mem_word(rd_addr_q) : ~rd_addr_q;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: no final result after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic pick_fields();
        logic [31:0] r;
        logic [31:0] s;
        int          max_vl;
        r         = rand32();
        s         = rand32();
        op        = r[31] ? OP_STORE : OP_LOAD;
        mode      = addr_mode_e'(2'(r[30:24] % 7'd3));
        width     = elem_width_e'(2'(r[23:16] % 8'd3));
        max_vl    = VLEN / (8 << int'(width));
        vl        = (IDX_W + 1)'(1 + int'(r[15:8]) % max_vl);
        vm        = (r[7:5] == 3'd0);
        base_addr = rand32();
        stride    = {{20{s[11]}}, s[11:0]};
        mask      = (VLEN / 8)'(rand32());
        for (int w = 0; w < VLEN / 32; w++) begin
            store_data[w*32 +: 32] = rand32();
            index[w*32 +: 32]      = rand32();
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        reset_n    = 1'b0;
        start      = 1'b0;
        op         = OP_LOAD;
        mode       = MODE_UNIT;
        width      = EW8;
        base_addr  = '0;
        stride     = '0;
        vl         = (IDX_W + 1)'(1);
        vm         = 1'b1;
        mask       = '0;
        store_data = '0;
        index      = '0;
        repeat (2) @(posedge clk);
        #2;
        reset_n = 1'b1;
        @(posedge clk);
        #2;
        for (int n = 0; n < N_XFER; n++) begin
            pick_fields();
            pulse_start();
            r = rand32();
            // A second start while busy must be ignored
            if (r[31]) begin
                @(posedge clk);
                #2;
                pick_fields();
                pulse_start();
            end
            do begin
                @(negedge clk);
            end while (!done);
            @(posedge clk);
            #2;
            if (r[30]) begin
                @(posedge clk);
                #2;
            end
        end
        // Counts settle at the falling edge, read them after the next rising edge
        repeat (2) @(posedge clk);
        $display("Transfers: %0d, checks: %0d, errors: %0d", N_XFER, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/vlsu_checker.sv ====
// Scoreboard for the vector load/store unit. Samples the DUT ports on the
// falling clock edge, rebuilds every expected memory access, busy and done
// from the start fields, and compares the load result at done.

`timescale 1ns/1ps
`default_nettype none

module vlsu_checker
    import vlsu_pkg::*;
#(
    parameter  int VLEN  = 128,
    localparam int IDX_W = $clog2(VLEN / 8)
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 start_i,
    input  lsu_op_e              op_i,
    input  addr_mode_e           mode_i,
    input  elem_width_e          width_i,
    input  logic [31:0]          base_addr_i,
    input  logic [31:0]          stride_i,
    input  logic [IDX_W:0]       vl_i,
    input  logic                 vm_i,
    input  logic [VLEN/8-1:0]    mask_i,
    input  logic [VLEN-1:0]      store_data_i,
    input  logic [VLEN-1:0]      index_i,
    input  logic [31:0]          mem_addr_i,
    input  logic                 mem_read_en_i,
    input  logic [BUS_BYTES-1:0] mem_write_en_i,
    input  logic [BUS_WIDTH-1:0] mem_write_data_i,
    input  logic                 busy_i,
    input  logic                 done_i,
    input  logic [VLEN-1:0]      read_data_i,
    output int                   check_count_o,
    output int                   error_count_o
);

    // Captured transfer
    lsu_op_e           op_q;
    addr_mode_e        mode_q;
    elem_width_e       width_q;
    logic [31:0]       base_q;
    logic [31:0]       stride_q;
    int                vl_q;
    logic              vm_q;
    logic [VLEN/8-1:0] mask_q;
    logic [VLEN-1:0]   sdata_q;
    logic [VLEN-1:0]   index_q;

    logic              run = 1'b0;
    int                k = 0;
    logic [VLEN-1:0]   img_exp = '0;
    string             tname = "reset";
    int                checks = 0;
    int                errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Same address mixing as the memory model in the testbench
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ 32'h5bd1_e995;
        h = h * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    function automatic int elem_bytes();
        return 1 << int'(width_q);
    endfunction

    function automatic logic [31:0] field_mask();
        if (elem_bytes() == 4) begin
            return 32'hffff_ffff;
        end
        return (32'd1 << (8 * elem_bytes())) - 32'd1;
    endfunction

    function automatic logic [31:0] get_elem(input logic [VLEN-1:0] v, input int i);
        return 32'(v >> (i * 8 * elem_bytes())) & field_mask();
    endfunction

    function automatic logic [31:0] elem_addr(input int i);
        logic [31:0] off;
        if (mode_q == MODE_INDEXED) begin
            off = get_elem(index_q, i);
        end else if (mode_q == MODE_UNIT) begin
            off = 32'(i * elem_bytes());
        end else begin
            off = 32'(i) * stride_q;
        end
        return base_q + off;
    endfunction

    // Elements sit at their naturally aligned lane
    function automatic logic [1:0] lane_of(input logic [31:0] addr);
        return addr[1:0] & ~2'(elem_bytes() - 1);
    endfunction

    function automatic logic [3:0] byte_en(input logic [31:0] addr);
        return 4'((1 << elem_bytes()) - 1) << lane_of(addr);
    endfunction

    function automatic logic [31:0] replicate(input logic [31:0] e);
        logic [31:0] w;
        for (int b = 0; b < BUS_BYTES; b++) begin
            w[b*8 +: 8] = e[(b % elem_bytes())*8 +: 8];
        end
        return w;
    endfunction

    function automatic logic [VLEN-1:0] load_image();
        logic [VLEN-1:0] img;
        logic [31:0]     a;
        logic [31:0]     e;
        img = '0;
        for (int i = 0; i < vl_q; i++) begin
            if (vm_q || mask_q[i]) begin
                a   = elem_addr(i);
                e   = (mem_word(a) >> (8 * int'(lane_of(a)))) & field_mask();
                img = img | (VLEN'(e) << (i * 8 * elem_bytes()));
            end
        end
        return img;
    endfunction

    task automatic compare(input string what, input logic [VLEN-1:0] exp,
                           input logic [VLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s %s at %0t: expected %0h, actual %0h",
                     tname, what, $time, exp, act);
        end
    endtask

    //////////////////////////////
    // Cycle checks
    //////////////////////////////

    always @(negedge clk) begin
        int          i;
        logic [31:0] a;
        logic        active;
        logic        exp_busy;
        logic        exp_done;
        logic        exp_rd;
        logic [3:0]  exp_we;
        if (!reset_n) begin
            run     = 1'b0;
            k       = 0;
            img_exp = '0;
            tname   = "reset";
            compare("busy", '0, VLEN'(busy_i));
            compare("done", '0, VLEN'(done_i));
            compare("read enable", '0, VLEN'(mem_read_en_i));
            compare("write enable", '0, VLEN'(mem_write_en_i));
            compare("read data", '0, read_data_i);
        end else begin
            if (run) begin
                k = k + 1;
            end
            exp_busy = run;
            exp_done = run && (k == vl_q + 2);
            exp_rd   = 1'b0;
            exp_we   = 4'b0000;
            // Element k-1 is on the memory ports
            if (run && k <= vl_q) begin
                i      = k - 1;
                a      = elem_addr(i);
                active = vm_q || mask_q[i];
                compare($sformatf("addr elem %0d", i), VLEN'(a), VLEN'(mem_addr_i));
                if (active && op_q == OP_LOAD) begin
                    exp_rd = 1'b1;
                end
                if (active && op_q == OP_STORE) begin
                    exp_we = byte_en(a);
                    compare($sformatf("write data elem %0d", i),
                            VLEN'(replicate(get_elem(sdata_q, i))),
                            VLEN'(mem_write_data_i));
                end
            end
            compare("read enable", VLEN'(exp_rd), VLEN'(mem_read_en_i));
            compare("write enable", VLEN'(exp_we), VLEN'(mem_write_en_i));
            compare("busy", VLEN'(exp_busy), VLEN'(busy_i));
            compare("done", VLEN'(exp_done), VLEN'(done_i));
            if (exp_done) begin
                run = 1'b0;
                if (op_q == OP_LOAD) begin
                    img_exp = load_image();
                end
            end
            // Result is held between transfers
            if (!run) begin
                compare("read data", img_exp, read_data_i);
            end
            if (start_i && !exp_busy) begin
                op_q     = op_i;
                mode_q   = mode_i;
                width_q  = width_i;
                base_q   = base_addr_i;
                stride_q = stride_i;
                vl_q     = int'(vl_i);
                vm_q     = vm_i;
                mask_q   = mask_i;
                sdata_q  = store_data_i;
                index_q  = index_i;
                tname    = $sformatf("%s/%s/%s", op_i.name(), mode_i.name(), width_i.name());
                run      = 1'b1;
                k        = 0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vlsu_top.sv ====
// Top level of the vector load/store unit. Chains sequencer, address stage
// and return stage. Start to done latency is vl+2 cycles.

`timescale 1ns/1ps
`default_nettype none

module vlsu_top
    import vlsu_pkg::*;
#(
    parameter  int VLEN  = 128,
    localparam int IDX_W = $clog2(VLEN / 8)
) (
    input  logic                 clk,
    input  logic                 reset_n,
    // Start interface
    input  logic                 start_i,
    input  lsu_op_e              op_i,
    input  addr_mode_e           mode_i,
    input  elem_width_e          width_i,
    input  logic [31:0]          base_addr_i,
    input  logic [31:0]          stride_i,
    input  logic [IDX_W:0]       vl_i,
    input  logic                 vm_i,
    input  logic [VLEN/8-1:0]    mask_i,
    input  logic [VLEN-1:0]      store_data_i,
    input  logic [VLEN-1:0]      index_i,
    // Memory interface
    output logic [31:0]          mem_addr_o,
    output logic                 mem_read_en_o,
    output logic [BUS_BYTES-1:0] mem_write_en_o,
    output logic [BUS_WIDTH-1:0] mem_write_data_o,
    input  logic [BUS_WIDTH-1:0] mem_read_data_i,
    // Result interface
    output logic                 busy_o,
    output logic                 done_o,
    output logic [VLEN-1:0]      read_data_o
);

    // Sequencer to address stage
    logic              issue_valid;
    logic [IDX_W-1:0]  elem_idx;
    logic              last;
    lsu_op_e           op;
    addr_mode_e        mode;
    elem_width_e       width;
    logic [31:0]       base;
    logic [31:0]       stride;
    logic              vm;
    logic [VLEN/8-1:0] mask;
    logic [VLEN-1:0]   store_data;
    logic [VLEN-1:0]   index;

    // Address stage to return stage
    logic              ret_valid;
    logic [IDX_W-1:0]  ret_idx;
    logic [1:0]        ret_lane;
    elem_width_e       ret_width;
    logic              ret_last;
    logic              ret_clear;

    vlsu_sequencer #(.VLEN(VLEN)) u_sequencer (
        .clk           (clk),
        .reset_n       (reset_n),
        .start_i       (start_i),
        .op_i          (op_i),
        .mode_i        (mode_i),
        .width_i       (width_i),
        .base_addr_i   (base_addr_i),
        .stride_i      (stride_i),
        .vl_i          (vl_i),
        .vm_i          (vm_i),
        .mask_i        (mask_i),
        .store_data_i  (store_data_i),
        .index_i       (index_i),
        .ret_last_i    (ret_last),
        .issue_valid_o (issue_valid),
        .elem_idx_o    (elem_idx),
        .last_o        (last),
        .op_o          (op),
        .mode_o        (mode),
        .width_o       (width),
        .base_o        (base),
        .stride_o      (stride),
        .vm_o          (vm),
        .mask_o        (mask),
        .store_data_o  (store_data),
        .index_o       (index),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    vlsu_address_stage #(.VLEN(VLEN)) u_address_stage (
        .clk              (clk),
        .reset_n          (reset_n),
        .issue_valid_i    (issue_valid),
        .elem_idx_i       (elem_idx),
        .last_i           (last),
        .op_i             (op),
        .mode_i           (mode),
        .width_i          (width),
        .base_i           (base),
        .stride_i         (stride),
        .vm_i             (vm),
        .mask_i           (mask),
        .store_data_i     (store_data),
        .index_i          (index),
        .mem_addr_o       (mem_addr_o),
        .mem_read_en_o    (mem_read_en_o),
        .mem_write_en_o   (mem_write_en_o),
        .mem_write_data_o (mem_write_data_o),
        .ret_valid_o      (ret_valid),
        .ret_idx_o        (ret_idx),
        .ret_lane_o       (ret_lane),
        .ret_width_o      (ret_width),
        .ret_last_o       (ret_last),
        .ret_clear_o      (ret_clear)
    );

    vlsu_return_stage #(.VLEN(VLEN)) u_return_stage (
        .clk             (clk),
        .reset_n         (reset_n),
        .mem_read_data_i (mem_read_data_i),
        .ret_valid_i     (ret_valid),
        .ret_idx_i       (ret_idx),
        .ret_lane_i      (ret_lane),
        .ret_width_i     (ret_width),
        .ret_clear_i     (ret_clear),
        .read_data_o     (read_data_o)
    );

endmodule

`default_nettype wire

// ==== hw/vlsu_return_stage.sv ====
// Third stage of the load/store unit. Picks the returned element out of the
// bus word and writes it into the vector register image.
// The image is cleared at the first element of each load.

`timescale 1ns/1ps
`default_nettype none

module vlsu_return_stage
    import vlsu_pkg::*;
#(
    parameter  int VLEN  = 128,
    localparam int IDX_W = $clog2(VLEN / 8)
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic [BUS_WIDTH-1:0] mem_read_data_i,
    input  logic                 ret_valid_i,
    input  logic [IDX_W-1:0]     ret_idx_i,
    input  logic [1:0]           ret_lane_i,
    input  elem_width_e          ret_width_i,
    input  logic                 ret_clear_i,
    output logic [VLEN-1:0]      read_data_o
);

    logic [VLEN-1:0]      image_r;
    logic [VLEN-1:0]      image_next;
    logic [BUS_WIDTH-1:0] lane_data;

    // Shift the addressed lane down to bit 0
    assign lane_data = mem_read_data_i >> (ret_lane_i * 8);

    //////////////////////////////
    // Image update
    //////////////////////////////

    always_comb begin
        image_next = ret_clear_i ? '0 : image_r;
        if (ret_valid_i) begin
            unique case (ret_width_i)
                EW8:     image_next[ret_idx_i*8 +: 8]   = lane_data[7:0];
                EW16:    image_next[ret_idx_i*16 +: 16] = lane_data[15:0];
                default: image_next[ret_idx_i*32 +: 32] = lane_data;
            endcase
        end
    end

    // Masked-off elements keep the zero from the clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            image_r <= '0;
        end else if (ret_valid_i || ret_clear_i) begin
            image_r <= image_next;
        end
    end

    assign read_data_o = image_r;

endmodule

`default_nettype wire

// ==== hw/vlsu_address_stage.sv ====
// Second stage of the load/store unit. Turns the issued element index into a
// memory access: address, read enable, byte enables and lane-aligned store
// data. Return information is registered to line up with the read data.

`timescale 1ns/1ps
`default_nettype none

module vlsu_address_stage
    import vlsu_pkg::*;
#(
    parameter  int VLEN  = 128,
    localparam int IDX_W = $clog2(VLEN / 8)
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 issue_valid_i,
    input  logic [IDX_W-1:0]     elem_idx_i,
    input  logic                 last_i,
    input  lsu_op_e              op_i,
    input  addr_mode_e           mode_i,
    input  elem_width_e          width_i,
    input  logic [31:0]          base_i,
    input  logic [31:0]          stride_i,
    input  logic                 vm_i,
    input  logic [VLEN/8-1:0]    mask_i,
    input  logic [VLEN-1:0]      store_data_i,
    input  logic [VLEN-1:0]      index_i,
    output logic [31:0]          mem_addr_o,
    output logic                 mem_read_en_o,
    output logic [BUS_BYTES-1:0] mem_write_en_o,
    output logic [BUS_WIDTH-1:0] mem_write_data_o,
    output logic                 ret_valid_o,
    output logic [IDX_W-1:0]     ret_idx_o,
    output logic [1:0]           ret_lane_o,
    output elem_width_e          ret_width_o,
    output logic                 ret_last_o,
    output logic                 ret_clear_o
);

    logic [31:0]          offset_r;
    logic [31:0]          run_offset;
    logic [31:0]          step;
    logic [31:0]          index_elem;
    logic [31:0]          addr;
    logic [1:0]           lane;
    logic [BUS_BYTES-1:0] byte_en;
    logic [BUS_WIDTH-1:0] wdata;
    logic                 active;

    //////////////////////////////
    // Address generation
    //////////////////////////////

    // Element 0 always starts at the base
    assign run_offset = (elem_idx_i == '0) ? 32'd0 : offset_r;
    assign step       = (mode_i == MODE_UNIT) ? (32'd1 << width_i) : stride_i;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            offset_r <= '0;
        end else if (issue_valid_i) begin
            offset_r <= run_offset + step;
        end
    end

    always_comb begin
        unique case (width_i)
            EW8:     index_elem = {24'd0, index_i[elem_idx_i*8 +: 8]};
            EW16:    index_elem = {16'd0, index_i[elem_idx_i*16 +: 16]};
            default: index_elem = index_i[elem_idx_i*32 +: 32];
        endcase
    end

    assign addr = base_i + ((mode_i == MODE_INDEXED) ? index_elem : run_offset);

    //////////////////////////////
    // Lanes and store data
    //////////////////////////////

    // Misaligned low bits are dropped, elements sit in their natural lane
    always_comb begin
        unique case (width_i)
            EW8: begin
                lane    = addr[1:0];
                byte_en = 4'b0001 << addr[1:0];
                wdata   = {4{store_data_i[elem_idx_i*8 +: 8]}};
            end
            EW16: begin
                lane    = {addr[1], 1'b0};
                byte_en = addr[1] ? 4'b1100 : 4'b0011;
                wdata   = {2{store_data_i[elem_idx_i*16 +: 16]}};
            end
            default: begin
                lane    = 2'b00;
                byte_en = 4'b1111;
                wdata   = store_data_i[elem_idx_i*32 +: 32];
            end
        endcase
    end

    assign active = vm_i || mask_i[elem_idx_i];

    assign mem_addr_o       = addr;
    assign mem_read_en_o    = issue_valid_i && (op_i == OP_LOAD) && active;
    assign mem_write_en_o   = (issue_valid_i && (op_i == OP_STORE) && active) ? byte_en : '0;
    assign mem_write_data_o = wdata;

    //////////////////////////////
    // Return pipeline register
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ret_valid_o <= 1'b0;
            ret_last_o  <= 1'b0;
            ret_clear_o <= 1'b0;
        end else begin
            ret_valid_o <= mem_read_en_o;
            ret_last_o  <= issue_valid_i && last_i;
            // Image is cleared only when a load begins
            ret_clear_o <= issue_valid_i && (elem_idx_i == '0) && (op_i == OP_LOAD);
        end
    end

    always_ff @(posedge clk) begin
        ret_idx_o   <= elem_idx_i;
        ret_lane_o  <= lane;
        ret_width_o <= width_i;
    end

endmodule

`default_nettype wire

// ==== hw/vlsu_sequencer.sv ====
// First stage of the load/store unit. Captures the instruction fields on an
// accepted start, then issues one element index per cycle and closes the
// transfer with a done strobe once the last load word has been captured.

`timescale 1ns/1ps
`default_nettype none

module vlsu_sequencer
    import vlsu_pkg::*;
#(
    parameter  int VLEN  = 128,
    localparam int IDX_W = $clog2(VLEN / 8)
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start_i,
    input  lsu_op_e           op_i,
    input  addr_mode_e        mode_i,
    input  elem_width_e       width_i,
    input  logic [31:0]       base_addr_i,
    input  logic [31:0]       stride_i,
    input  logic [IDX_W:0]    vl_i,
    input  logic              vm_i,
    input  logic [VLEN/8-1:0] mask_i,
    input  logic [VLEN-1:0]   store_data_i,
    input  logic [VLEN-1:0]   index_i,
    // Last element has reached the return stage
    input  logic              ret_last_i,
    output logic              issue_valid_o,
    output logic [IDX_W-1:0]  elem_idx_o,
    output logic              last_o,
    output lsu_op_e           op_o,
    output addr_mode_e        mode_o,
    output elem_width_e       width_o,
    output logic [31:0]       base_o,
    output logic [31:0]       stride_o,
    output logic              vm_o,
    output logic [VLEN/8-1:0] mask_o,
    output logic [VLEN-1:0]   store_data_o,
    output logic [VLEN-1:0]   index_o,
    output logic              busy_o,
    output logic              done_o
);

    lsu_state_e       state;
    logic [IDX_W-1:0] elem_cnt;
    logic [IDX_W:0]   vl_r;
    logic             accept;

    // Busy also covers the done cycle, so back-to-back starts wait one cycle
    assign busy_o = (state != LSU_IDLE) || done_o;
    assign accept = start_i && !busy_o;

    assign issue_valid_o = (state == LSU_ISSUE);
    assign elem_idx_o    = elem_cnt;
    assign last_o        = ({1'b0, elem_cnt} + (IDX_W + 1)'(1)) == vl_r;

    //////////////////////////////
    // Transfer FSM
    //////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= LSU_IDLE;
            elem_cnt <= '0;
            done_o   <= 1'b0;
        end else begin
            done_o <= 1'b0;
            unique case (state)
                LSU_IDLE: begin
                    if (accept) begin
                        state    <= LSU_ISSUE;
                        elem_cnt <= '0;
                    end
                end
                LSU_ISSUE: begin
                    elem_cnt <= elem_cnt + 1'b1;
                    if (last_o) begin
                        state <= LSU_DRAIN;
                    end
                end
                LSU_DRAIN: begin
                    // Last return word is written into the image this cycle
                    if (ret_last_i) begin
                        state  <= LSU_IDLE;
                        done_o <= 1'b1;
                    end
                end
                default: state <= LSU_IDLE;
            endcase
        end
    end

    // Instruction fields held for the whole transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o         <= op_i;
            mode_o       <= mode_i;
            width_o      <= width_i;
            base_o       <= base_addr_i;
            stride_o     <= stride_i;
            vl_r         <= vl_i;
            vm_o         <= vm_i;
            mask_o       <= mask_i;
            store_data_o <= store_data_i;
            index_o      <= index_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/vlsu_pkg.sv ====
// Shared types and bus constants for the vector load/store unit.
// Imported by every RTL stage and by the testbench.

`default_nettype none

package vlsu_pkg;

    //////////////////////////////
    // Bus constants
    //////////////////////////////

    // Lane logic assumes four byte lanes
    localparam int BUS_WIDTH = 32;
    localparam int BUS_BYTES = BUS_WIDTH / 8;

    //////////////////////////////
    // Instruction fields
    //////////////////////////////

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } lsu_op_e;

    typedef enum logic [1:0] {
        MODE_UNIT    = 2'd0,
        MODE_STRIDED = 2'd1,
        MODE_INDEXED = 2'd2
    } addr_mode_e;

    // Encoded as log2 of the element size in bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    // Sequencer FSM
    typedef enum logic [1:0] {
        LSU_IDLE  = 2'd0,
        LSU_ISSUE = 2'd1,
        LSU_DRAIN = 2'd2
    } lsu_state_e;

endpackage

`default_nettype wire
